// File: common/fill_pkg.sv
/* framebuffer geometry, address and payload types, register map
   and status layout for the rectangle-fill unit. */
`default_nettype none

package fill_pkg;

    // framebuffer geometry.
    localparam int FB_COLS = 16;
    localparam int FB_ROWS = 8;
    localparam int BYTES_PER_PIXEL = 3;
    localparam int FB_BYTES = FB_COLS * FB_ROWS * BYTES_PER_PIXEL;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [3:0] col_addr_t;
    typedef logic [2:0] row_addr_t;
    typedef logic [4:0] col_count_t;  // up to 16.
    typedef logic [3:0] row_count_t;  // up to 8.
    typedef logic [1:0] byte_sel_t;
    typedef logic [8:0] fb_addr_t;
    typedef logic [11:0] apb_addr_t;

    // byte n of the color is bytes[n].
    typedef struct packed {
        logic [BYTES_PER_PIXEL-1:0][7:0] bytes;
    } color_t;

    // one framebuffer byte write.
    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
        byte_sel_t byte_sel;
        logic [7:0] data;
    } fb_write_t;

    typedef struct packed {
        col_addr_t x1;
        row_addr_t y1;
        col_count_t width;
        row_count_t height;
    } fill_region_t;

    // bit 1 done, bit 0 busy.
    typedef struct packed {
        logic done;
        logic busy;
    } status_t;

    // APB register map.
    localparam apb_addr_t REG_CTRL = 12'h000;
    localparam apb_addr_t REG_STATUS = 12'h004;
    localparam apb_addr_t REG_X1 = 12'h008;
    localparam apb_addr_t REG_Y1 = 12'h00C;
    localparam apb_addr_t REG_WIDTH = 12'h010;
    localparam apb_addr_t REG_HEIGHT = 12'h014;
    localparam apb_addr_t REG_COLOR = 12'h018;

    // framebuffer byte n sits at FB_WINDOW + 4n.
    localparam apb_addr_t FB_WINDOW = 12'h400;
    localparam apb_addr_t FB_WINDOW_END = apb_addr_t'(FB_WINDOW + 4 * FB_BYTES);

endpackage

`default_nettype wire

// File: fill/fill_area_engine.sv
/* rectangle walker: steps byte, column and row across the region
   and emits one framebuffer byte write per accepted push. */
`timescale 1ns/1ps
`default_nettype none

module fill_area_engine (
    input wire logic clk,
    input wire logic reset,
    input wire logic start,
    input wire logic ack,
    input wire fill_pkg::fill_region_t region,
    input wire fill_pkg::color_t color,
    output fill_pkg::fb_write_t wr_item,
    output logic wr_valid,
    input wire logic full,
    output logic busy,
    output logic done
);

    typedef enum logic [1:0] {
        s_idle,
        s_write,
        s_wait_ack
    } state_t;

    state_t state;

    fill_pkg::col_addr_t x1_q;
    fill_pkg::col_addr_t last_col;
    fill_pkg::row_addr_t last_row;
    fill_pkg::color_t color_q;

    fill_pkg::row_addr_t row;
    fill_pkg::col_addr_t col;
    fill_pkg::byte_sel_t byte_sel;

    logic last_step;

    // last column and row of the incoming region, inclusive.
    fill_pkg::col_count_t col_end;
    fill_pkg::row_count_t row_end;

    assign col_end = fill_pkg::col_count_t'(region.x1) + region.width - 5'd1;
    assign row_end = fill_pkg::row_count_t'(region.y1) + region.height - 4'd1;

    assign last_step = (row == last_row) && (col == last_col) && (byte_sel == '0);

    always_comb begin
        wr_item.row = row;
        wr_item.col = col;
        wr_item.byte_sel = byte_sel;
        wr_item.data = color_q.bytes[byte_sel];  // msb byte first.
    end

    // region bounds and color captured at start.
    always_ff @(posedge clk) begin
        if (state == s_idle && start) begin
            x1_q <= region.x1;
            last_col <= fill_pkg::col_addr_t'(col_end);
            last_row <= fill_pkg::row_addr_t'(row_end);
            color_q <= color;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
            wr_valid <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            row <= '0;
            col <= '0;
            byte_sel <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_write;
                        row <= region.y1;
                        col <= region.x1;
                        byte_sel <= fill_pkg::byte_sel_t'(fill_pkg::BYTES_PER_PIXEL - 1);
                        wr_valid <= 1'b1;
                        busy <= 1'b1;
                    end
                end
                s_write: begin
                    if (!full) begin  // item taken by the FIFO.
                        if (last_step) begin
                            state <= s_wait_ack;
                            wr_valid <= 1'b0;
                            busy <= 1'b0;
                            done <= 1'b1;
                        end else if (byte_sel == '0) begin
                            byte_sel <= fill_pkg::byte_sel_t'(fill_pkg::BYTES_PER_PIXEL - 1);
                            if (col == last_col) begin
                                col <= x1_q;
                                row <= row + 3'd1;
                            end else begin
                                col <= col + 4'd1;
                            end
                        end else begin
                            byte_sel <= byte_sel - 2'd1;
                        end
                    end
                end
                s_wait_ack: begin
                    // start is ignored here.
                    if (ack) begin
                        state <= s_idle;
                        done <= 1'b0;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/write_fifo.sv
/* synchronous FIFO with a type-parameterised payload. */
`timescale 1ns/1ps
`default_nettype none

module write_fifo #(
    parameter type payload_t = fill_pkg::fb_write_t
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic push,
    input wire payload_t push_item,
    output logic full,
    input wire logic pop,
    output payload_t pop_item,
    output logic not_empty,
    output logic empty
);

    payload_t mem [fill_pkg::FIFO_DEPTH];

    logic [fill_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [fill_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [fill_pkg::FIFO_PTR_W:0] count;

    logic push_ok;
    logic pop_ok;

    assign full = (count == (fill_pkg::FIFO_PTR_W + 1)'(fill_pkg::FIFO_DEPTH));
    assign empty = (count == '0);
    assign not_empty = !empty;

    assign push_ok = push && !full;
    assign pop_ok = pop && !empty;

    assign pop_item = mem[rd_ptr];  // head visible the cycle after push.

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two.
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;  // both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/framebuffer.sv
/* byte-wide framebuffer RAM with a drain write port and a
   synchronous host read port. */
`timescale 1ns/1ps
`default_nettype none

module framebuffer (
    input wire logic clk,
    input wire logic reset,
    input wire fill_pkg::fb_write_t wr_item,
    input wire logic wr_valid,
    output logic wr_take,
    input wire logic rd_en,
    input wire fill_pkg::fb_addr_t rd_addr,
    output logic [7:0] rd_data
);

    logic [7:0] ram [fill_pkg::FB_BYTES];

    fill_pkg::fb_addr_t pixel_index;
    fill_pkg::fb_addr_t wr_addr;

    // ram starts blank in simulation.
    initial begin
        for (int i = 0; i < fill_pkg::FB_BYTES; i++) begin
            ram[i] = 8'h00;
        end
    end

    // drain every cycle the FIFO has data.
    assign wr_take = wr_valid;

    // row * 16 + col, then 3 bytes per pixel.
    assign pixel_index = fill_pkg::fb_addr_t'({wr_item.row, wr_item.col});
    assign wr_addr = pixel_index * fill_pkg::fb_addr_t'(fill_pkg::BYTES_PER_PIXEL)
                   + fill_pkg::fb_addr_t'(wr_item.byte_sel);

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            ram[wr_addr] <= wr_item.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= 8'h00;
        end else if (rd_en) begin
            rd_data <= ram[rd_addr];  // one cycle read.
        end
    end

endmodule

`default_nettype wire

// File: hdl/fill_regs.sv
/* APB slave: geometry and color registers, start and status
   control, geometry checks and the framebuffer read window. */
`timescale 1ns/1ps
`default_nettype none

module fill_regs (
    input wire logic clk,
    input wire logic reset,
    input wire fill_pkg::apb_addr_t paddr,
    input wire logic psel,
    input wire logic penable,
    input wire logic pwrite,
    input wire logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output fill_pkg::fill_region_t region,
    output fill_pkg::color_t color,
    output logic start,
    output logic ack,
    input wire logic busy,
    input wire logic done,
    input wire logic fifo_empty,
    output logic rd_en,
    output fill_pkg::fb_addr_t rd_addr,
    input wire logic [7:0] rd_data
);

    fill_pkg::status_t status;

    logic win_hit;
    logic rd_pending;  // RAM read issued last cycle.
    logic wr_access;
    logic start_req;
    logic geom_ok;
    logic busy_any;
    logic refuse;

    logic [5:0] col_sum;
    logic [4:0] row_sum;

    assign win_hit = (paddr >= fill_pkg::FB_WINDOW) && (paddr < fill_pkg::FB_WINDOW_END);
    assign rd_addr = fill_pkg::fb_addr_t'((paddr - fill_pkg::FB_WINDOW) >> 2);

    assign wr_access = psel && penable && pwrite;
    assign rd_en = psel && penable && !pwrite && win_hit && !rd_pending;

    // one wait state on window reads only.
    assign pready = psel && penable && (pwrite || !win_hit || rd_pending);

    // a start pulse in flight counts as busy.
    assign busy_any = busy || !fifo_empty || start;
    assign status.busy = busy || !fifo_empty;
    assign status.done = done && fifo_empty;

    assign col_sum = 6'(region.x1) + 6'(region.width);
    assign row_sum = 5'(region.y1) + 5'(region.height);
    assign geom_ok = (region.width != '0) && (region.height != '0)
                   && (col_sum <= 6'(fill_pkg::FB_COLS))
                   && (row_sum <= 5'(fill_pkg::FB_ROWS));

    assign start_req = wr_access && (paddr == fill_pkg::REG_CTRL) && pwdata[0];
    assign refuse = start_req && (!geom_ok || busy_any);
    assign pslverr = refuse;

    always_ff @(posedge clk) begin
        if (reset) begin
            region <= '0;
            start <= 1'b0;
            ack <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            start <= start_req && !refuse;
            ack <= wr_access && (paddr == fill_pkg::REG_STATUS) && pwdata[1];  // w1c.
            rd_pending <= rd_en;
            if (wr_access) begin
                case (paddr)
                    fill_pkg::REG_X1: region.x1 <= pwdata[3:0];
                    fill_pkg::REG_Y1: region.y1 <= pwdata[2:0];
                    fill_pkg::REG_WIDTH: region.width <= pwdata[4:0];
                    fill_pkg::REG_HEIGHT: region.height <= pwdata[3:0];
                    default: ;
                endcase
            end
        end
    end

    // fill color register.
    always_ff @(posedge clk) begin
        if (wr_access && paddr == fill_pkg::REG_COLOR) begin
            color <= pwdata[23:0];
        end
    end

    always_comb begin
        prdata = 32'h0;
        if (win_hit) begin
            prdata = {24'h0, rd_data};
        end else begin
            case (paddr)
                fill_pkg::REG_STATUS: prdata = {30'h0, status};
                fill_pkg::REG_X1: prdata = {28'h0, region.x1};
                fill_pkg::REG_Y1: prdata = {29'h0, region.y1};
                fill_pkg::REG_WIDTH: prdata = {27'h0, region.width};
                fill_pkg::REG_HEIGHT: prdata = {28'h0, region.height};
                fill_pkg::REG_COLOR: prdata = {8'h0, color};
                default: prdata = 32'h0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/fill_top.sv
/* top level: register block, fill engine, write FIFO and framebuffer. */
`timescale 1ns/1ps
`default_nettype none

module fill_top (
    input wire logic clk,
    input wire logic reset,
    input wire fill_pkg::apb_addr_t paddr,
    input wire logic psel,
    input wire logic penable,
    input wire logic pwrite,
    input wire logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr
);

    fill_pkg::fill_region_t region;
    fill_pkg::color_t color;
    fill_pkg::fb_write_t wr_item;
    fill_pkg::fb_write_t rd_item;
    fill_pkg::fb_addr_t rd_addr;

    logic start;
    logic ack;
    logic busy;
    logic done;
    logic wr_valid;
    logic full;
    logic not_empty;
    logic fifo_empty;
    logic wr_take;  // framebuffer pop.
    logic rd_en;
    logic [7:0] rd_data;

    fill_regs u_regs (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .region(region), .color(color), .start(start), .ack(ack),
        .busy(busy), .done(done), .fifo_empty(fifo_empty),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    fill_area_engine u_engine (
        .clk(clk), .reset(reset), .start(start), .ack(ack),
        .region(region), .color(color),
        .wr_item(wr_item), .wr_valid(wr_valid), .full(full),
        .busy(busy), .done(done)
    );

    write_fifo #(.payload_t(fill_pkg::fb_write_t)) u_fifo (
        .clk(clk), .reset(reset),
        .push(wr_valid), .push_item(wr_item), .full(full),
        .pop(wr_take), .pop_item(rd_item),
        .not_empty(not_empty), .empty(fifo_empty)
    );

    framebuffer u_fb (
        .clk(clk), .reset(reset),
        .wr_item(rd_item), .wr_valid(not_empty), .wr_take(wr_take),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
/* free-running testbench clock, 4 ns period. */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 2 ns high, 2 ns low.
    end

endmodule

`default_nettype wire

// File: bench/fill_chk.sv
/* FIFO assertions on held items while full, underflow and count bound,
   and the bind that attaches them to every write_fifo. */
`timescale 1ns/1ps
`default_nettype none

module fill_chk (
    input wire logic clk,
    input wire logic reset,
    input wire logic push,
    input wire fill_pkg::fb_write_t push_item,
    input wire logic full,
    input wire logic pop,
    input wire logic empty,
    input wire logic [fill_pkg::FIFO_PTR_W:0] count
);

    int unsigned violations = 0;  // failed assertions so far.

    // an offered item is held, not dropped, while full.
    no_push_full: assert property (@(posedge clk) disable iff (reset)
        (push && full) |=> (push && $stable(push_item)))
        else begin
            violations++;
            $error("offered item changed or was withdrawn while the FIFO was full");
        end

    no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        !(pop && empty))
        else begin
            violations++;
            $error("pop requested while the FIFO was empty");
        end

    count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= (fill_pkg::FIFO_PTR_W + 1)'(fill_pkg::FIFO_DEPTH))
        else begin
            violations++;
            $error("FIFO count above its depth");
        end

endmodule

bind write_fifo fill_chk u_chk (
    .clk(clk), .reset(reset), .push(push), .push_item(push_item),
    .full(full), .pop(pop), .empty(empty), .count(count)
);

`default_nettype wire

// File: bench/fill_tb.sv
/* directed tests for the fill unit: APB driver tasks, framebuffer
   model, LFSR stimulus and compare tasks. */
`timescale 1ns/1ps
`default_nettype none

module fill_tb;

    localparam int APB_TIMEOUT = 16;  // cycles of wait state per transfer.
    localparam int DONE_POLLS = 400;
    localparam fill_pkg::status_t ST_IDLE = '{done: 1'b0, busy: 1'b0};
    localparam fill_pkg::status_t ST_DONE = '{done: 1'b1, busy: 1'b0};

    logic clk;
    logic reset;
    fill_pkg::apb_addr_t paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;

    logic [7:0] model [fill_pkg::FB_BYTES];  // expected framebuffer.
    logic [31:0] lfsr;

    tb_clock u_clock (.clk(clk));

    fill_top dut (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // byte address of a pixel byte.
    function automatic fill_pkg::fb_addr_t fb_index(input int row, input int col, input int b);
        return fill_pkg::fb_addr_t'((row * fill_pkg::FB_COLS + col) * fill_pkg::BYTES_PER_PIXEL + b);
    endfunction

    task automatic apb_transfer(input logic write, input fill_pkg::apb_addr_t addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        @(negedge clk);
        psel = 1'b1;  // setup phase.
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        waited = 0;
        #1;
        while (!pready) begin
            if (waited == APB_TIMEOUT) begin
                fail_now("APB transfer timed out waiting for pready");
            end
            @(negedge clk);
            #1;
            waited++;
        end
        rdata = prdata;
        err = pslverr;
        @(negedge clk);  // completing edge has passed.
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input fill_pkg::apb_addr_t addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input fill_pkg::apb_addr_t addr, output logic [31:0] data);
        logic err;
        apb_transfer(1'b0, addr, 32'h0, data, err);
        if (err) begin
            fail_now($sformatf("read of address %h was answered with pslverr", addr));
        end
    endtask

    task automatic write_ok(input fill_pkg::apb_addr_t addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        if (err) begin
            fail_now($sformatf("write to address %h was answered with pslverr", addr));
        end
    endtask

    task automatic compare_byte(input int index, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] fb[%0d]: got %h expected %h", index, got, exp));
        end
    endtask

    task automatic compare_status(input fill_pkg::status_t got, input fill_pkg::status_t exp,
                                  input string what);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] status (%s): got %h expected %h", what, got, exp));
        end
    endtask

    task automatic compare_reg(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic expect_status(input fill_pkg::status_t exp, input string what);
        logic [31:0] d;
        apb_read(fill_pkg::REG_STATUS, d);
        compare_status(fill_pkg::status_t'(d[1:0]), exp, what);
    endtask

    task automatic check_reg(input string name, input fill_pkg::apb_addr_t addr,
                             input logic [31:0] value);
        logic [31:0] d;
        write_ok(addr, value);
        apb_read(addr, d);
        compare_reg(name, d, value);
    endtask

    task automatic check_framebuffer();
        logic [31:0] d;
        for (int i = 0; i < fill_pkg::FB_BYTES; i++) begin
            apb_read(fill_pkg::apb_addr_t'(fill_pkg::FB_WINDOW + 4 * i), d);
            compare_byte(i, d[7:0], model[fill_pkg::fb_addr_t'(i)]);
        end
    endtask

    task automatic model_fill(input int x1, input int y1, input int w, input int h,
                              input logic [23:0] color);
        for (int r = y1; r < y1 + h; r++) begin
            for (int c = x1; c < x1 + w; c++) begin
                for (int b = 0; b < fill_pkg::BYTES_PER_PIXEL; b++) begin
                    model[fb_index(r, c, b)] = color[8 * b +: 8];
                end
            end
        end
    endtask

    task automatic program_region(input int x1, input int y1, input int w, input int h,
                                  input logic [23:0] color);
        write_ok(fill_pkg::REG_X1, 32'(x1));
        write_ok(fill_pkg::REG_Y1, 32'(y1));
        write_ok(fill_pkg::REG_WIDTH, 32'(w));
        write_ok(fill_pkg::REG_HEIGHT, 32'(h));
        write_ok(fill_pkg::REG_COLOR, {8'h0, color});
    endtask

    task automatic start_fill(input logic expect_err);
        logic err;
        apb_write(fill_pkg::REG_CTRL, 32'h1, err);
        if (err !== expect_err) begin
            fail_now($sformatf("[ERROR] pslverr on start: got %h expected %h", err, expect_err));
        end
    endtask

    task automatic wait_done();
        logic [31:0] d;
        int polls;
        polls = 0;
        apb_read(fill_pkg::REG_STATUS, d);
        while (!d[1]) begin
            if (polls == DONE_POLLS) begin
                fail_now("fill did not report done in time");
            end
            apb_read(fill_pkg::REG_STATUS, d);
            polls++;
        end
    endtask

    task automatic run_fill(input int x1, input int y1, input int w, input int h,
                            input logic [23:0] color);
        program_region(x1, y1, w, h, color);
        start_fill(1'b0);
        wait_done();
        expect_status(ST_DONE, "fill finished");
        write_ok(fill_pkg::REG_STATUS, 32'h2);  // clear done.
        expect_status(ST_IDLE, "done cleared");
        model_fill(x1, y1, w, h, color);
    endtask

    task automatic test_reset_and_regs();
        expect_status(ST_IDLE, "after reset");
        check_reg("REG_X1", fill_pkg::REG_X1, 32'ha);
        check_reg("REG_Y1", fill_pkg::REG_Y1, 32'h5);
        check_reg("REG_WIDTH", fill_pkg::REG_WIDTH, 32'h13);
        check_reg("REG_HEIGHT", fill_pkg::REG_HEIGHT, 32'h9);
        check_reg("REG_COLOR", fill_pkg::REG_COLOR, 32'h5a3cc1);
    endtask

    task automatic test_random_fills();
        logic [31:0] v;
        int x1;
        int y1;
        int w;
        int h;
        take_bits(24, v);
        run_fill(0, 0, fill_pkg::FB_COLS, fill_pkg::FB_ROWS, v[23:0]);  // whole framebuffer.
        check_framebuffer();
        repeat (4) begin
            take_bits(4, v);
            x1 = int'(v);
            take_bits(4, v);
            w = 1 + int'(v) % (fill_pkg::FB_COLS - x1);
            take_bits(3, v);
            y1 = int'(v);
            take_bits(3, v);
            h = 1 + int'(v) % (fill_pkg::FB_ROWS - y1);
            take_bits(24, v);
            run_fill(x1, y1, w, h, v[23:0]);
            check_framebuffer();
        end
    endtask

    task automatic test_refused();
        program_region(0, 0, 0, 4, 24'h123456);  // zero width.
        start_fill(1'b1);
        expect_status(ST_IDLE, "zero width refused");
        program_region(10, 0, 7, 2, 24'h123456);
        start_fill(1'b1);
        expect_status(ST_IDLE, "column overrun refused");
        program_region(0, 4, 3, 5, 24'h123456);
        start_fill(1'b1);
        expect_status(ST_IDLE, "row overrun refused");
        check_framebuffer();
    endtask

    task automatic test_start_while_done();
        program_region(3, 2, 4, 3, 24'h0f1e2d);
        start_fill(1'b0);
        wait_done();
        model_fill(3, 2, 4, 3, 24'h0f1e2d);
        write_ok(fill_pkg::REG_COLOR, 32'h00a5b6c7);
        start_fill(1'b0);  // engine still waits for ack.
        expect_status(ST_DONE, "start while done");
        check_framebuffer();
        write_ok(fill_pkg::REG_STATUS, 32'h2);
        expect_status(ST_IDLE, "done cleared");
        start_fill(1'b0);
        wait_done();
        write_ok(fill_pkg::REG_STATUS, 32'h2);
        model_fill(3, 2, 4, 3, 24'ha5b6c7);
        check_framebuffer();
    endtask

    initial begin
        lfsr = 32'hd1055e4b;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        for (int i = 0; i < fill_pkg::FB_BYTES; i++) begin
            model[fill_pkg::fb_addr_t'(i)] = 8'h00;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_and_regs();
        run_fill(5, 3, 1, 1, 24'hc0ffee);  // single pixel, rest stays blank.
        check_framebuffer();
        test_random_fills();
        run_fill(2, 1, 6, 4, 24'h112233);  // two overlapping rectangles.
        run_fill(5, 3, 7, 4, 24'h8899aa);
        check_framebuffer();
        test_refused();
        test_start_while_done();

        if (dut.u_fifo.u_chk.violations != 0) begin
            fail_now("a FIFO assertion failed during the run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
common/fill_pkg.sv
fill/fill_area_engine.sv
hdl/write_fifo.sv
hdl/framebuffer.sv
hdl/fill_regs.sv
hdl/fill_top.sv
bench/tb_clock.sv
bench/fill_chk.sv
bench/fill_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fill_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := ERRORS FOUND

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
